//--- led_calib_consts.svh
`ifndef LED_CALIB_CONSTS_SVH
`define LED_CALIB_CONSTS_SVH

// small active frame so a full calibration run stays short
`define H_ACTIVE 16
// pixels per line, blanking included
`define H_TOTAL 20

// active lines
`define V_ACTIVE 8
// lines per frame, blanking included
`define V_TOTAL 10

// one capture frame per address bit
`define ADDR_BITS 5

// one table entry per active pixel
`define PIX_COUNT 128

`endif

//--- led_calib_pkg.sv
`include "led_calib_consts.svh"

package led_calib_pkg;

    // one cycle of video timing
    typedef struct packed {
        logic [$clog2(`H_TOTAL)-1:0] hcount;
        logic [$clog2(`V_TOTAL)-1:0] vcount;
        logic                        active;
        logic                        new_frame;
    } timing_t;

    // chroma pair for one pixel
    typedef struct packed {
        logic [7:0] cr;
        logic [7:0] cb;
    } chroma_t;

    // inclusive bounds, shared by both channels
    typedef struct packed {
        logic [7:0] lower;
        logic [7:0] upper;
    } thresh_cfg_t;

    // classified pixel with its coordinate
    typedef struct packed {
        logic    seen0;
        logic    seen1;
        timing_t timing;
    } detect_t;

    // step control toward the table
    typedef struct packed {
        logic                          capture;
        logic                          first;
        logic [$clog2(`ADDR_BITS)-1:0] bit_index;
    } calib_ctrl_t;

    // table readout, one per active pixel in DONE
    typedef struct packed {
        logic                        valid;
        logic [`ADDR_BITS-1:0]       id;
        logic [$clog2(`H_TOTAL)-1:0] hcount;
        logic [$clog2(`V_TOTAL)-1:0] vcount;
    } led_id_t;

    typedef enum logic [1:0] {
        IDLE,
        SETTLE,
        CAPTURE,
        DONE
    } calib_state_e;

endpackage

//--- video_timing.sv
`timescale 1ns/1ps
`include "led_calib_consts.svh"

module video_timing (
    input  logic                   clk_pixel,
    input  logic                   sys_rst_pixel,
    output led_calib_pkg::timing_t timing
);

    localparam int HCNT_W = $clog2(`H_TOTAL);
    localparam int VCNT_W = $clog2(`V_TOTAL);

    logic [HCNT_W-1:0] hcount;
    logic [VCNT_W-1:0] vcount;
    logic              h_last;
    logic              v_last;

    // last pixel of a line, last line of a frame
    assign h_last = (hcount == HCNT_W'(`H_TOTAL - 1));
    assign v_last = (vcount == VCNT_W'(`V_TOTAL - 1));

    // free running raster scan
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            hcount <= '0;
            vcount <= '0;
        end else if (h_last) begin
            hcount <= '0;
            // wrap the frame after the last blanking line
            if (v_last) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + VCNT_W'(1);
            end
        end else begin
            hcount <= hcount + HCNT_W'(1);
        end
    end

    assign timing.hcount = hcount;
    assign timing.vcount = vcount;

    // active region sits at the top left of the raster
    assign timing.active = (hcount < HCNT_W'(`H_ACTIVE)) && (vcount < VCNT_W'(`V_ACTIVE));

    // origin marks the frame start
    assign timing.new_frame = (hcount == '0) && (vcount == '0);

endmodule

//--- chroma_threshold.sv
`timescale 1ns/1ps

module chroma_threshold (
    input  logic                       clk_pixel,
    input  logic                       sys_rst_pixel,
    input  led_calib_pkg::thresh_cfg_t cfg,
    input  led_calib_pkg::chroma_t     pix,
    input  led_calib_pkg::timing_t     timing,
    output led_calib_pkg::detect_t     detect
);

    // pix trails timing by one cycle, so hold the coordinate one stage
    led_calib_pkg::timing_t timing_d;
    logic                   cb_in;
    logic                   cr_in;

    // inclusive window on each channel
    assign cb_in = (pix.cb >= cfg.lower) && (pix.cb <= cfg.upper);
    assign cr_in = (pix.cr >= cfg.lower) && (pix.cr <= cfg.upper);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            timing_d <= '0;
            detect   <= '0;
        end else begin
            timing_d <= timing;
            // blue channel carries bit 1
            detect.seen1 <= cb_in;
            // both passing counts as bit 1, so red alone means bit 0
            detect.seen0 <= cr_in && !cb_in;
            // coordinate now matches the classified pixel
            detect.timing <= timing_d;
        end
    end

endmodule

//--- calib_step_fsm.sv
`timescale 1ns/1ps
`include "led_calib_consts.svh"

module calib_step_fsm (
    input  logic                       clk_pixel,
    input  logic                       sys_rst_pixel,
    input  logic                       start,
    input  logic                       new_frame,
    output led_calib_pkg::calib_ctrl_t ctrl,
    output logic                       busy,
    output logic                       done
);

    localparam int BIT_W = $clog2(`ADDR_BITS);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`ADDR_BITS - 1);

    led_calib_pkg::calib_state_e state;
    led_calib_pkg::calib_state_e state_next;
    logic [BIT_W-1:0]            bit_idx;
    logic [BIT_W-1:0]            bit_idx_next;
    led_calib_pkg::calib_ctrl_t  ctrl_next;

    // next state and address bit
    always_comb begin
        state_next   = state;
        bit_idx_next = bit_idx;
        case (state)
            led_calib_pkg::IDLE,
            led_calib_pkg::DONE: begin
                // fresh run from bit 0
                if (start) begin
                    state_next   = led_calib_pkg::SETTLE;
                    bit_idx_next = '0;
                end
            end
            led_calib_pkg::SETTLE: begin
                // strip shows the new bit during this frame
                if (new_frame) begin
                    state_next = led_calib_pkg::CAPTURE;
                end
            end
            led_calib_pkg::CAPTURE: begin
                // exactly one frame of capture
                if (new_frame) begin
                    if (bit_idx == LAST_BIT) begin
                        state_next = led_calib_pkg::DONE;
                    end else begin
                        state_next   = led_calib_pkg::SETTLE;
                        bit_idx_next = bit_idx + BIT_W'(1);
                    end
                end
            end
            default: begin
                state_next = led_calib_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            state   <= led_calib_pkg::IDLE;
            bit_idx <= '0;
        end else begin
            state   <= state_next;
            bit_idx <= bit_idx_next;
        end
    end

    // control as seen against the undelayed timing
    always_comb begin
        ctrl_next.capture   = (state == led_calib_pkg::CAPTURE);
        ctrl_next.first     = (state == led_calib_pkg::CAPTURE) && (bit_idx == '0);
        ctrl_next.bit_index = bit_idx;
    end

    // one stage late, so capture covers the detect stream frame exactly
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

    assign busy = (state == led_calib_pkg::SETTLE) || (state == led_calib_pkg::CAPTURE);
    assign done = (state == led_calib_pkg::DONE);

endmodule

//--- led_id_table.sv
`timescale 1ns/1ps
`include "led_calib_consts.svh"

module led_id_table (
    input  logic                       clk_pixel,
    input  logic                       sys_rst_pixel,
    input  led_calib_pkg::detect_t     detect,
    input  led_calib_pkg::calib_ctrl_t ctrl,
    input  logic                       done,
    output led_calib_pkg::led_id_t     readout
);

    localparam int ADDR_W = $clog2(`PIX_COUNT);

    // one entry per active pixel
    typedef struct packed {
        logic                  valid;
        logic [`ADDR_BITS-1:0] id;
    } entry_t;

    entry_t                 mem [`PIX_COUNT];
    logic [ADDR_W-1:0]      addr;
    entry_t                 cur;
    entry_t                 upd;
    logic                   seen;
    logic                   wr_en;
    entry_t                 rd_entry;
    led_calib_pkg::timing_t rd_timing;
    logic                   rd_hit;

    // row major over the active frame
    assign addr  = ADDR_W'(detect.timing.vcount * `H_ACTIVE + detect.timing.hcount);
    assign seen  = detect.seen0 || detect.seen1;
    assign wr_en = ctrl.capture && detect.timing.active;

    // merge this step's bit into the stored entry
    always_comb begin
        cur = mem[addr];
        upd = cur;
        if (!seen) begin
            // nothing lit here this step
            upd.valid = 1'b0;
        end else begin
            // bit 0 starts the entry over
            if (ctrl.first) begin
                upd.id    = '0;
                upd.valid = 1'b1;
            end
            upd.id[ctrl.bit_index] = detect.seen1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[addr] <= upd;
        end
    end

    // registered read, coordinate rides along
    always_ff @(posedge clk_pixel) begin
        rd_entry  <= cur;
        rd_timing <= detect.timing;
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            rd_hit <= 1'b0;
        end else begin
            rd_hit <= done && detect.timing.active;
        end
    end

    // done also gates the output so a restart drops valid at once
    assign readout.valid  = rd_hit && done && rd_entry.valid;
    assign readout.id     = rd_entry.id;
    assign readout.hcount = rd_timing.hcount;
    assign readout.vcount = rd_timing.vcount;

endmodule

//--- led_calib_top.sv
`timescale 1ns/1ps
`include "led_calib_consts.svh"

module led_calib_top (
    input  logic                          clk_pixel,
    input  logic                          sys_rst_pixel,
    input  logic                          start,
    input  led_calib_pkg::thresh_cfg_t    cfg,
    input  led_calib_pkg::chroma_t        pix,
    output led_calib_pkg::timing_t        timing,
    output logic [$clog2(`ADDR_BITS)-1:0] bit_index,
    output logic                          busy,
    output logic                          done,
    output led_calib_pkg::led_id_t        readout
);

    // classified pixels, two cycles behind timing
    led_calib_pkg::detect_t     detect;
    led_calib_pkg::calib_ctrl_t ctrl;

    // address bit the strip should show
    assign bit_index = ctrl.bit_index;

    video_timing timing_i (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .timing        (timing)
    );

    chroma_threshold thresh_i (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .cfg           (cfg),
        .pix           (pix),
        .timing        (timing),
        .detect        (detect)
    );

    // frame boundaries from the undelayed timing
    calib_step_fsm fsm_i (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .start         (start),
        .new_frame     (timing.new_frame),
        .ctrl          (ctrl),
        .busy          (busy),
        .done          (done)
    );

    // readout lands three cycles after its timing coordinate,
    // and carries that coordinate with it
    led_id_table table_i (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .detect        (detect),
        .ctrl          (ctrl),
        .done          (done),
        .readout       (readout)
    );

endmodule

//--- led_calib_asserts.sv
`timescale 1ns/1ps
`include "led_calib_consts.svh"

module led_calib_asserts (
    input logic                          clk_pixel,
    input logic                          sys_rst_pixel,
    input logic                          start,
    input logic                          busy,
    input logic                          done,
    input logic [$clog2(`ADDR_BITS)-1:0] bit_index,
    input led_calib_pkg::led_id_t        readout
);

    // a run is either in progress or finished, never both
    busy_done_excl: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        !(busy && done)) else $error("busy and done high together");

    // bit counter stops at the last address bit
    bit_index_range: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        bit_index < `ADDR_BITS) else $error("bit_index past the last address bit");

    // table output only means something once calibration is done
    valid_only_done: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        readout.valid |-> done) else $error("readout valid outside DONE");

    // start from idle or done begins a run next cycle
    start_to_busy: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        start && !busy |=> busy) else $error("start did not begin a run");

endmodule

bind led_calib_top led_calib_asserts asserts_i (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .bit_index     (bit_index),
    .readout       (readout)
);

//--- led_calib_tb.sv
`timescale 1ns/1ps
`include "led_calib_consts.svh"

module led_calib_tb;

    localparam int FRAME = `H_TOTAL * `V_TOTAL;
    // settle and capture per bit, start slack and readout frames
    localparam int RUN_CYCLES = (2 * `ADDR_BITS + 2) * FRAME;
    localparam int WATCHDOG_NS = (2 * RUN_CYCLES + 4 * FRAME) * 20;
    localparam int RUN_WORDS = 2 + 3 * `V_ACTIVE;
    localparam int HW = $clog2(`H_TOTAL);
    localparam int VW = $clog2(`V_TOTAL);
    localparam int BW = $clog2(`ADDR_BITS);
    localparam int ID_W = `ADDR_BITS;
    localparam logic [31:0] SEED = 32'h0073_3a8e;

    logic                       clk_pixel;
    logic                       sys_rst_pixel;
    logic                       start;
    led_calib_pkg::thresh_cfg_t cfg;
    led_calib_pkg::chroma_t     pix;
    led_calib_pkg::timing_t     timing;
    logic [BW-1:0]              bit_index;
    logic                       busy;
    logic                       done;
    led_calib_pkg::led_id_t     readout;

    logic [7:0]             trace_mem [2 * RUN_WORDS];
    logic [7:0]             row_base [`V_ACTIVE];
    logic [7:0]             row_step [`V_ACTIVE];
    logic [7:0]             row_mode [`V_ACTIVE];
    int                     amb_step [`V_ACTIVE];
    // expected timing of the last three cycles, newest first
    led_calib_pkg::timing_t hist [3];
    led_calib_pkg::timing_t samp_t;
    int                     samp_bidx;
    logic                   readout_check;
    int                     mismatch_count;
    int                     fail_count;

    led_calib_top dut_i (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .start         (start),
        .cfg           (cfg),
        .pix           (pix),
        .timing        (timing),
        .bit_index     (bit_index),
        .busy          (busy),
        .done          (done),
        .readout       (readout)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #10 clk_pixel = ~clk_pixel;
    end

    // uniform value inside the inclusive window
    function automatic logic [7:0] in_range(led_calib_pkg::thresh_cfg_t c);
        return c.lower + 8'($urandom % (c.upper - c.lower + 1));
    endfunction

    // uniform value outside the window
    function automatic logic [7:0] out_range(led_calib_pkg::thresh_cfg_t c);
        int width;
        int r;
        width = int'(c.upper - c.lower + 1);
        r = int'($urandom % (256 - width));
        return (r < int'(c.lower)) ? 8'(r) : 8'(r + width);
    endfunction

    function automatic logic [ID_W-1:0] pixel_id(int h, int v);
        return ID_W'(row_base[v] + row_step[v] * h);
    endfunction

    // strip pattern as the camera sees it for one coordinate
    function automatic led_calib_pkg::chroma_t scene_pixel(led_calib_pkg::timing_t t, int bidx);
        led_calib_pkg::chroma_t p;
        logic [ID_W-1:0]        id;
        int                     v;
        logic                   dark;
        p.cr = out_range(cfg);
        p.cb = out_range(cfg);
        if (t.active) begin
            v = int'(t.vcount);
            id = pixel_id(int'(t.hcount), v);
            dark = (row_mode[v] == 8'h01) || (row_mode[v] == 8'h02 && amb_step[v] == bidx);
            // blue means bit 1, red means bit 0
            if (!dark && id[bidx]) begin
                p.cb = in_range(cfg);
            end else if (!dark) begin
                p.cr = in_range(cfg);
            end
        end
        return p;
    endfunction

    task automatic check_timing(led_calib_pkg::timing_t got, led_calib_pkg::timing_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: timing %0d,%0d,%0b,%0b expected %0d,%0d,%0b,%0b",
                $time, got.hcount, got.vcount, got.active, got.new_frame,
                want.hcount, want.vcount, want.active, want.new_frame);
        end
    endtask

    task automatic check_led_id(led_calib_pkg::led_id_t got, led_calib_pkg::led_id_t want);
        logic bad;
        // id is don't care when the entry is not valid
        bad = (got.valid !== want.valid) || (got.hcount !== want.hcount)
            || (got.vcount !== want.vcount) || (want.valid && got.id !== want.id);
        if (bad) begin
            mismatch_count++;
            $display("mismatch at %0t: readout (%0d,%0d) v=%0b id=%0d expected (%0d,%0d) v=%0b id=%0d",
                $time, got.hcount, got.vcount, got.valid, got.id,
                want.hcount, want.vcount, want.valid, want.id);
        end
    endtask

    task automatic check_flag(logic got, logic want, string what);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %0b, expected %0b", $time, what, got, want);
        end
    endtask

    task automatic check_bit_index(logic [BW-1:0] got, logic [BW-1:0] want);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: bit_index is %0d, expected %0d", $time, got, want);
        end
    endtask

    // pixel answers the coordinate seen one cycle earlier
    always @(posedge clk_pixel) begin
        pix <= scene_pixel(samp_t, samp_bidx);
    end

    // raster model, stimulus sampling and readout checks
    initial begin
        led_calib_pkg::timing_t want_t;
        led_calib_pkg::led_id_t want_r;
        int h;
        int v;
        int rv;
        h = 0;
        v = 0;
        forever begin
            @(negedge clk_pixel);
            if (!sys_rst_pixel) begin
                want_t = '{hcount: HW'(h), vcount: VW'(v),
                    active: (h < `H_ACTIVE) && (v < `V_ACTIVE), new_frame: (h == 0) && (v == 0)};
                check_timing(timing, want_t);
                samp_t = timing;
                samp_bidx = int'(bit_index);
                if (!done) begin
                    check_flag(readout.valid, 1'b0, "readout.valid outside DONE");
                end
                // readout trails its coordinate by three cycles
                if (readout_check) begin
                    want_r = '0;
                    want_r.hcount = hist[2].hcount;
                    want_r.vcount = hist[2].vcount;
                    if (hist[2].active) begin
                        rv = int'(hist[2].vcount);
                        want_r.valid = (row_mode[rv] == 8'h00);
                        want_r.id = pixel_id(int'(hist[2].hcount), rv);
                    end
                    check_led_id(readout, want_r);
                    check_flag(done, 1'b1, "done during readout");
                end
                hist[2] = hist[1];
                hist[1] = hist[0];
                hist[0] = want_t;
                h++;
                if (h == `H_TOTAL) begin
                    h = 0;
                    v = (v == `V_TOTAL - 1) ? 0 : v + 1;
                end
            end
        end
    end

    task automatic run_calibration(int run, logic poke_busy);
        int base;
        int cyc;
        int last_change;
        int expect_bit;
        logic seen_done;
        base = run * RUN_WORDS;
        @(negedge clk_pixel);
        for (int r = 0; r < `V_ACTIVE; r++) begin
            row_base[r] = trace_mem[base + 2 + 3 * r];
            row_step[r] = trace_mem[base + 3 + 3 * r];
            row_mode[r] = trace_mem[base + 4 + 3 * r];
            amb_step[r] = int'($urandom % `ADDR_BITS);
        end
        @(posedge clk_pixel);
        cfg <= '{lower: trace_mem[base], upper: trace_mem[base + 1]};
        start <= 1'b1;
        @(posedge clk_pixel);
        start <= 1'b0;
        @(negedge clk_pixel);
        check_flag(busy, 1'b1, "busy after start");
        check_flag(done, 1'b0, "done after start");
        // ctrl is one stage behind the FSM
        @(negedge clk_pixel);
        check_bit_index(bit_index, '0);
        cyc = 0;
        last_change = -1;
        expect_bit = 0;
        seen_done = 1'b0;
        while (!seen_done && cyc < RUN_CYCLES) begin
            @(negedge clk_pixel);
            cyc++;
            if (done) begin
                seen_done = 1'b1;
            end else begin
                check_flag(busy, 1'b1, "busy during run");
                if (bit_index != BW'(expect_bit)) begin
                    check_bit_index(bit_index, BW'(expect_bit + 1));
                    if (last_change >= 0 && cyc - last_change != 2 * FRAME) begin
                        fail_count++;
                        $display("bit_index stepped %0d cycles after the previous step",
                            cyc - last_change);
                    end
                    last_change = cyc;
                    expect_bit = int'(bit_index);
                end
            end
            // a start pulse in the middle of a run
            if (poke_busy && cyc == 3 * FRAME) begin
                @(posedge clk_pixel);
                start <= 1'b1;
            end else if (poke_busy && cyc == 3 * FRAME + 1) begin
                @(posedge clk_pixel);
                start <= 1'b0;
            end
        end
        if (!seen_done) begin
            fail_count++;
            $display("run %0d never reached DONE", run);
        end else begin
            check_bit_index(bit_index, BW'(`ADDR_BITS - 1));
            check_flag(busy, 1'b0, "busy in DONE");
            if (cyc - last_change != 2 * FRAME - 1) begin
                fail_count++;
                $display("done rose %0d cycles after the last bit step", cyc - last_change);
            end
            @(posedge clk_pixel);
            readout_check = 1'b1;
            repeat (2 * FRAME) @(posedge clk_pixel);
            readout_check = 1'b0;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        sys_rst_pixel = 1'b1;
        start = 1'b0;
        cfg = '0;
        pix = '0;
        samp_t = '0;
        samp_bidx = 0;
        hist = '{default: '0};
        readout_check = 1'b0;
        mismatch_count = 0;
        fail_count = 0;
        $readmemh("led_calib_trace.txt", trace_mem);
        if (trace_mem[1] <= trace_mem[0] || trace_mem[RUN_WORDS + 1] <= trace_mem[RUN_WORDS]) begin
            fail_count++;
            $display("trace file missing or its bounds are not ordered");
        end
        repeat (10) @(posedge clk_pixel);
        sys_rst_pixel <= 1'b0;
        @(negedge clk_pixel);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(readout.valid, 1'b0, "readout.valid after reset");
        check_bit_index(bit_index, '0);
        run_calibration(0, 1'b0);
        // restart from DONE with the second scene
        run_calibration(1, 1'b1);
        $display("error counts: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- led_calib_trace.txt
// per run: lower and upper bound, then one line per active row: base id, id step, mode
// mode 00 lit, 01 dark, 02 ambiguous (dark in one random step)
28 3c
00 01 00
10 01 00
1f 1f 00
03 02 01
05 03 00
0a 05 02
11 07 00
1c 0b 00
90 c0
07 03 00
12 1d 02
00 04 00
1a 01 00
15 09 01
0e 06 00
1f 01 02
04 0d 00

//--- build.f
+incdir+.
led_calib_pkg.sv
video_timing.sv
chroma_threshold.sv
calib_step_fsm.sv
led_id_table.sv
led_calib_top.sv
led_calib_asserts.sv
led_calib_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the calibration testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module led_calib_tb -o led_calib_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/led_calib_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
